// File: hdl/lsu_defines.svh
`ifndef LSU_DEFINES_SVH
`define LSU_DEFINES_SVH

// Data path widths.
`define LSU_DATA_W 32
`define LSU_BYTE_W 8

// One RAM per byte lane of the data word.
`define LSU_LANES 4

// Word address inside a lane, taken from addr above the byte offset.
`define LSU_WORD_AW 8
`define LSU_WORD_LSB 2
`define LSU_WORD_DEPTH (1 << `LSU_WORD_AW)

`endif

// File: hdl/lsu_pkg.sv
`include "lsu_defines.svh"

package lsu_pkg;

    typedef enum logic [1:0] {
        ACCESS_OP_M2R = 2'd0,  // Load.
        ACCESS_OP_R2M = 2'd1,  // Store.
        ACCESS_OP_D2R = 2'd2   // Data straight back to register.
    } access_op_e;

    typedef enum logic [1:0] {
        ACCESS_SZ_BYTE = 2'd0,
        ACCESS_SZ_HALF = 2'd1,
        ACCESS_SZ_WORD = 2'd2
    } access_sz_e;

    typedef enum logic [1:0] {
        CTRL_IDLE = 2'd0,
        CTRL_READ = 2'd1,  // Lane read in flight.
        CTRL_DONE = 2'd2
    } ctrl_state_e;

    // One access as issued by the requester.
    typedef struct packed {
        access_op_e             op;
        access_sz_e             size;
        logic                   is_unsigned;
        logic [`LSU_DATA_W-1:0] addr;
        logic [`LSU_DATA_W-1:0] wdata;
    } mem_req_t;

    typedef struct packed {
        logic                   we;
        logic [`LSU_WORD_AW-1:0] addr;  // Shared by read and write.
        logic [`LSU_BYTE_W-1:0] data;
    } lane_wr_t;

endpackage

// File: hdl/mem_align.sv
`timescale 1ns/1ns
`include "lsu_defines.svh"

module mem_align
    import lsu_pkg::*;
(
    input  mem_req_t                               req_i,
    input  logic                                   wr_allow_i,
    input  logic [`LSU_LANES-1:0][`LSU_BYTE_W-1:0] rd_bytes_i,
    output lane_wr_t [`LSU_LANES-1:0]              lane_wr_o,
    output logic                                   misaligned_o,
    output logic [`LSU_DATA_W-1:0]                 load_data_o
);

    logic [`LSU_LANES-1:0]   byte_en;
    logic [`LSU_DATA_W-1:0]  store_data;
    logic [`LSU_DATA_W-1:0]  rd_word;
    logic [15:0]             rd_half;
    logic [7:0]              rd_byte;
    logic                    mem_op;
    logic                    wr_en;
    logic [`LSU_WORD_AW-1:0] word_addr;

    assign rd_word   = rd_bytes_i;
    assign word_addr = req_i.addr[`LSU_WORD_AW+`LSU_WORD_LSB-1:`LSU_WORD_LSB];
    assign mem_op    = (req_i.op == ACCESS_OP_M2R) || (req_i.op == ACCESS_OP_R2M);

    // Lane selection and the matching slice of the read word.
    always_comb begin
        rd_half = 16'h0;
        rd_byte = 8'h0;
        case (req_i.size)
            ACCESS_SZ_BYTE: begin
                byte_en = 4'b0001 << req_i.addr[1:0];
                rd_byte = rd_bytes_i[req_i.addr[1:0]];
            end
            ACCESS_SZ_HALF: begin
                byte_en = req_i.addr[1] ? 4'b1100 : 4'b0011;
                rd_half = req_i.addr[1] ? rd_word[31:16] : rd_word[15:0];
            end
            default: begin
                byte_en = 4'b1111;
            end
        endcase
    end

    // Replicate narrow store data so every enabled lane sees its byte.
    always_comb begin
        case (req_i.size)
            ACCESS_SZ_BYTE: store_data = {4{req_i.wdata[7:0]}};
            ACCESS_SZ_HALF: store_data = {2{req_i.wdata[15:0]}};
            default:        store_data = req_i.wdata;
        endcase
    end

    always_comb begin
        if (req_i.op == ACCESS_OP_M2R) begin
            case (req_i.size)
                ACCESS_SZ_BYTE: begin
                    load_data_o = req_i.is_unsigned ? {24'h0, rd_byte}
                                                    : {{24{rd_byte[7]}}, rd_byte};
                end
                ACCESS_SZ_HALF: begin
                    load_data_o = req_i.is_unsigned ? {16'h0, rd_half}
                                                    : {{16{rd_half[15]}}, rd_half};
                end
                default: begin
                    load_data_o = rd_word;
                end
            endcase
        end else begin
            load_data_o = req_i.wdata;  // Store and pass-through echo the operand.
        end
    end

    always_comb begin
        case (req_i.size)
            ACCESS_SZ_BYTE: misaligned_o = 1'b0;
            ACCESS_SZ_HALF: misaligned_o = mem_op && req_i.addr[0];
            default:        misaligned_o = mem_op && (req_i.addr[1:0] != 2'b00);
        endcase
    end

    // The only write qualifier in the design.
    assign wr_en = wr_allow_i && (req_i.op == ACCESS_OP_R2M) && !misaligned_o;

    always_comb begin
        for (int i = 0; i < `LSU_LANES; i++) begin
            lane_wr_o[i].we   = wr_en && byte_en[i];
            lane_wr_o[i].addr = word_addr;
            lane_wr_o[i].data = store_data[i*`LSU_BYTE_W +: `LSU_BYTE_W];
        end
    end

endmodule

// File: hdl/byte_lane_ram.sv
`timescale 1ns/1ns
`include "lsu_defines.svh"

module byte_lane_ram
    import lsu_pkg::*;
(
    input  logic                    clk_i,
    input  lane_wr_t                wr_i,
    input  logic [`LSU_WORD_AW-1:0] rd_addr_i,
    output logic [`LSU_BYTE_W-1:0]  rd_byte_o
);

    logic [`LSU_BYTE_W-1:0] mem [`LSU_WORD_DEPTH];

    always_ff @(posedge clk_i) begin
        if (wr_i.we) begin
            mem[wr_i.addr] <= wr_i.data;
        end
    end

    // Registered read, one cycle after the address.
    always_ff @(posedge clk_i) begin
        rd_byte_o <= mem[rd_addr_i];
    end

endmodule

// File: hdl/mem_access_ctrl.sv
`timescale 1ns/1ns
`include "lsu_defines.svh"

module mem_access_ctrl
    import lsu_pkg::*;
(
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic                   psel_i,
    input  logic                   penable_i,
    input  mem_req_t               req_i,
    output logic                   pready_o,
    output logic                   pslverr_o,
    output logic [`LSU_DATA_W-1:0] prdata_o,
    output mem_req_t               held_req_o,
    output logic                   wr_allow_o,
    input  logic                   misaligned_i,
    input  logic [`LSU_DATA_W-1:0] load_data_i
);

    ctrl_state_e state_q;
    ctrl_state_e state_d;
    logic        capture;
    logic        done;

    assign capture = (state_q == CTRL_IDLE) && psel_i && !penable_i;  // Setup cycle.
    assign done    = (state_q == CTRL_DONE);

    always_comb begin
        state_d = state_q;
        case (state_q)
            CTRL_IDLE: begin
                if (capture) begin
                    state_d = CTRL_READ;
                end
            end
            CTRL_READ: begin
                state_d = CTRL_DONE;  // Lanes sample the address here.
            end
            CTRL_DONE: begin
                state_d = CTRL_IDLE;
            end
            default: begin
                state_d = CTRL_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= CTRL_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Request held for the whole transfer.
    always_ff @(posedge clk_i) begin
        if (capture) begin
            held_req_o <= req_i;
        end
    end

    assign pready_o   = done;
    assign wr_allow_o = done;  // Store lands on the completing edge.
    assign pslverr_o  = done && misaligned_i;
    assign prdata_o   = done ? load_data_i : '0;

endmodule

// File: hdl/lsu_top.sv
`timescale 1ns/1ns
`include "lsu_defines.svh"

module lsu_top
    import lsu_pkg::*;
(
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic                   psel_i,
    input  logic                   penable_i,
    input  mem_req_t               req_i,
    output logic                   pready_o,
    output logic                   pslverr_o,
    output logic [`LSU_DATA_W-1:0] prdata_o
);

    mem_req_t                               held_req;
    logic                                   wr_allow;
    logic                                   misaligned;
    logic [`LSU_DATA_W-1:0]                 load_data;
    logic [`LSU_LANES-1:0][`LSU_BYTE_W-1:0] rd_bytes;
    lane_wr_t [`LSU_LANES-1:0]              lane_wr;

    mem_access_ctrl mem_access_ctrl_inst (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .psel_i       (psel_i),
        .penable_i    (penable_i),
        .req_i        (req_i),
        .pready_o     (pready_o),
        .pslverr_o    (pslverr_o),
        .prdata_o     (prdata_o),
        .held_req_o   (held_req),
        .wr_allow_o   (wr_allow),
        .misaligned_i (misaligned),
        .load_data_i  (load_data)
    );

    mem_align mem_align_inst (
        .req_i        (held_req),
        .wr_allow_i   (wr_allow),
        .rd_bytes_i   (rd_bytes),
        .lane_wr_o    (lane_wr),
        .misaligned_o (misaligned),
        .load_data_o  (load_data)
    );

    // Lane g holds bits 8*g+7 down to 8*g of every word.
    for (genvar g = 0; g < `LSU_LANES; g++) begin : g_lane
        byte_lane_ram byte_lane_ram_inst (
            .clk_i     (clk_i),
            .wr_i      (lane_wr[g]),
            .rd_addr_i (lane_wr[g].addr),  // Same word address for read and write.
            .rd_byte_o (rd_bytes[g])
        );
    end

endmodule

// File: testbench/lsu_chk.sv
`timescale 1ns/1ns

module lsu_chk (
    input logic clk_i,
    input logic rst_n_i,
    input logic psel_i,
    input logic penable_i,
    input logic pready_i,
    input logic pslverr_i
);

    pready_in_access: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        pready_i |-> (psel_i && penable_i)
    ) else $error("pready high outside an APB access phase");

    // Not in the cycle where penable rises, but in the next one.
    pready_not_at_penable_rise: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        $rose(penable_i) |-> !pready_i
    ) else $error("pready high in the first access cycle");

    pready_after_penable_rise: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        $rose(penable_i) |=> pready_i
    ) else $error("pready missing one cycle after penable rose");

    pslverr_with_pready: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        pslverr_i |-> pready_i
    ) else $error("pslverr high without pready");

    pready_low_in_reset: assert property (
        @(posedge clk_i)
        (!rst_n_i && $past(!rst_n_i)) |-> !pready_i
    ) else $error("pready high while reset is held");

endmodule

bind mem_access_ctrl lsu_chk lsu_chk_inst (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .psel_i    (psel_i),
    .penable_i (penable_i),
    .pready_i  (pready_o),
    .pslverr_i (pslverr_o)
);

// File: testbench/lsu_monitor.sv
`timescale 1ns/1ns
`include "lsu_defines.svh"

module lsu_monitor
    import lsu_pkg::*;
(
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic                   psel_i,
    input  logic                   penable_i,
    input  mem_req_t               req_i,
    input  logic                   pready_i,
    input  logic                   pslverr_i,
    input  logic [`LSU_DATA_W-1:0] prdata_i,
    output int                     done_count_o,
    output int                     check_count_o,
    output int                     error_count_o
);

    logic [7:0] model [1024];  // Byte addressed by addr[9:0].
    logic       pending = 1'b0;
    int         edge_count = 0;
    int         setup_edge = 0;
    int         done_count = 0;
    int         check_count = 0;
    int         error_count = 0;

    assign done_count_o  = done_count;
    assign check_count_o = check_count;
    assign error_count_o = error_count;

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            $display("CHECK FAILED t=%0t %s expected 0x%h got 0x%h", $time, name, exp, got);
            error_count++;
        end
    endtask

    task automatic note_problem(input string msg);
        $display("ERROR t=%0t %s", $time, msg);
        error_count++;
    endtask

    // Expected response of the transfer in its access phase, then the model update.
    task automatic check_transfer();
        logic [9:0]  a;
        logic [31:0] exp_data;
        logic        exp_err;
        logic [7:0]  b;
        logic [15:0] h;
        a        = req_i.addr[9:0];
        exp_err  = 1'b0;
        exp_data = req_i.wdata;
        if (req_i.op != ACCESS_OP_D2R) begin
            if (req_i.size == ACCESS_SZ_HALF) begin
                exp_err = a[0];
            end else if (req_i.size == ACCESS_SZ_WORD) begin
                exp_err = (a[1:0] != 2'b00);
            end
        end
        compare_value("pslverr_o", {31'b0, pslverr_i}, {31'b0, exp_err});
        if (!exp_err && req_i.op == ACCESS_OP_M2R) begin
            b = model[a];
            h = {model[a + 10'd1], model[a]};
            case (req_i.size)
                ACCESS_SZ_BYTE: exp_data = req_i.is_unsigned ? {24'h0, b} : {{24{b[7]}}, b};
                ACCESS_SZ_HALF: exp_data = req_i.is_unsigned ? {16'h0, h} : {{16{h[15]}}, h};
                default: exp_data = {model[a + 10'd3], model[a + 10'd2], h};
            endcase
            compare_value("prdata_o", prdata_i, exp_data);
        end else if (req_i.op == ACCESS_OP_D2R) begin
            compare_value("prdata_o", prdata_i, exp_data);
        end else if (!exp_err && req_i.op == ACCESS_OP_R2M) begin
            model[a] = req_i.wdata[7:0];
            if (req_i.size != ACCESS_SZ_BYTE) begin
                model[a + 10'd1] = req_i.wdata[15:8];
            end
            if (req_i.size == ACCESS_SZ_WORD) begin
                model[a + 10'd2] = req_i.wdata[23:16];
                model[a + 10'd3] = req_i.wdata[31:24];
            end
        end
    endtask

    // Mid-cycle sampling, nothing changes here.
    always @(negedge clk_i) begin
        if (!rst_n_i) begin
            pending    = 1'b0;
            edge_count = 0;
            if (pready_i === 1'b1) begin
                note_problem("pready high while reset is held");
            end
        end else begin
            edge_count++;
            if (pslverr_i === 1'b1 && pready_i !== 1'b1) begin
                note_problem("pslverr high without pready");
            end
            if (pready_i === 1'b1) begin
                if (!(psel_i && penable_i)) begin
                    note_problem("pready high outside an APB access phase");
                end
                if (!pending) begin
                    note_problem("pready high with no transfer in flight");
                end else begin
                    if (edge_count - setup_edge != 2) begin
                        note_problem($sformatf("transfer took %0d cycles after setup, not 2",
                                               edge_count - setup_edge));
                    end
                    check_transfer();
                    done_count++;
                    pending = 1'b0;
                end
            end else if (pending && (edge_count - setup_edge >= 2)) begin
                note_problem("no pready two cycles after setup");
                pending = 1'b0;
            end
            if (psel_i && !penable_i && !pending) begin
                pending    = 1'b1;
                setup_edge = edge_count;
            end
        end
    end

endmodule

// File: testbench/lsu_tb.sv
`timescale 1ns/1ns
`include "lsu_defines.svh"

module lsu_tb
    import lsu_pkg::*;
();

    localparam int RESET_CYCLES = 10;
    localparam int INIT_COUNT   = `LSU_WORD_DEPTH;
    localparam int RAND_COUNT   = 400;
    localparam int CYCLE_LIMIT  = RESET_CYCLES + (INIT_COUNT + RAND_COUNT) * 4 + 100;

    logic                   clk;
    logic                   rst_n;
    logic                   psel;
    logic                   penable;
    mem_req_t               req;
    logic                   pready;
    logic                   pslverr;
    logic [`LSU_DATA_W-1:0] prdata;
    int                     done_count;
    int                     check_count;
    int                     error_count;
    int                     seed = 32'h82db;
    int                     cycle_count = 0;

    lsu_top lsu_top_inst (
        .clk_i     (clk),
        .rst_n_i   (rst_n),
        .psel_i    (psel),
        .penable_i (penable),
        .req_i     (req),
        .pready_o  (pready),
        .pslverr_o (pslverr),
        .prdata_o  (prdata)
    );

    lsu_monitor lsu_monitor_inst (
        .clk_i         (clk),
        .rst_n_i       (rst_n),
        .psel_i        (psel),
        .penable_i     (penable),
        .req_i         (req),
        .pready_i      (pready),
        .pslverr_i     (pslverr),
        .prdata_i      (prdata),
        .done_count_o  (done_count),
        .check_count_o (check_count),
        .error_count_o (error_count)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    // Called just after a rising edge, returns just after one. Setup, two access cycles, idle.
    task automatic apb_transfer(input mem_req_t r);
        #1;
        psel    = 1'b1;
        penable = 1'b0;
        req     = r;
        @(posedge clk);  // Setup edge.
        #1 penable = 1'b1;
        do begin
            @(negedge clk);
        end while (pready !== 1'b1);
        @(posedge clk);  // Completing edge.
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        @(posedge clk);
    endtask

    function automatic mem_req_t random_req();
        mem_req_t    r;
        logic [31:0] pick;
        logic [31:0] addr;
        pick = $random(seed);
        case (pick[2:0])
            3'd0, 3'd1, 3'd2: r.op = ACCESS_OP_M2R;
            3'd3, 3'd4, 3'd5: r.op = ACCESS_OP_R2M;
            default:          r.op = ACCESS_OP_D2R;
        endcase
        case (pick[5:4])
            2'd0:    r.size = ACCESS_SZ_BYTE;
            2'd1:    r.size = ACCESS_SZ_HALF;
            default: r.size = ACCESS_SZ_WORD;
        endcase
        r.is_unsigned = pick[8];
        addr = $random(seed);
        if (r.size == ACCESS_SZ_HALF) begin
            addr[0] = (pick[14:12] == 3'd0);  // About one in eight off alignment.
        end else if (r.size == ACCESS_SZ_WORD) begin
            addr[1:0] = (pick[14:12] == 3'd0) ? {pick[16], ~pick[16]} : 2'b00;
        end
        r.addr  = addr;
        r.wdata = $random(seed);
        return r;
    endfunction

    task automatic report_test(input string name, input int done_before, input int err_before);
        $display("test %s finished: %0d transfers, %0d errors", name,
                 done_count - done_before, error_count - err_before);
    endtask

    initial begin
        mem_req_t    r;
        logic [31:0] rnd;
        int          done_before;
        int          err_before;
        rst_n   = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        req     = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rst_n = 1'b1;
        repeat (3) @(posedge clk);  // Idle, pready must stay low.

        done_before = done_count;
        err_before  = error_count;
        for (int i = 0; i < INIT_COUNT; i++) begin
            rnd           = $random(seed);
            r.op          = ACCESS_OP_R2M;
            r.size        = ACCESS_SZ_WORD;
            r.is_unsigned = 1'b0;
            r.addr        = {rnd[31:10], i[7:0], 2'b00};  // Upper bits are don't care.
            r.wdata       = $random(seed);
            apb_transfer(r);
        end
        report_test("word_init", done_before, err_before);

        done_before = done_count;
        err_before  = error_count;
        for (int i = 0; i < RAND_COUNT; i++) begin
            apb_transfer(random_req());
        end
        report_test("random_mix", done_before, err_before);

        $display("summary: 2 tests, %0d transfers, %0d checks, %0d errors",
                 done_count, check_count, error_count);
        if (done_count != INIT_COUNT + RAND_COUNT) begin
            $display("Transfer count wrong: %0d issued, %0d completed",
                     INIT_COUNT + RAND_COUNT, done_count);
        end
        if (error_count == 0 && done_count == INIT_COUNT + RAND_COUNT) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: build.f
+incdir+hdl
hdl/lsu_pkg.sv
hdl/mem_align.sv
hdl/byte_lane_ram.sv
hdl/mem_access_ctrl.sv
hdl/lsu_top.sv
testbench/lsu_chk.sv
testbench/lsu_monitor.sv
testbench/lsu_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the LSU testbench with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

obj_dir="obj_dir"
sim_bin="lsu_sim"
log_file="sim.log"

verilator --binary --timing --assert \
    --top-module lsu_tb \
    -Mdir "${obj_dir}" -o "${sim_bin}" \
    -f build.f
status=$?
if [ "${status}" -ne 0 ]; then
    echo "Verilator build failed with status ${status}"
    exit 1
fi

# Keep running past assertion errors so the testbench prints its verdict.
"./${obj_dir}/${sim_bin}" +verilator+error+limit+1000 > "${log_file}" 2>&1
status=$?
cat "${log_file}"
if [ "${status}" -ne 0 ]; then
    echo "Simulation exited with status ${status}"
    exit 1
fi

if grep -qx "RESULT: PASS" "${log_file}"; then
    echo "Simulation passed"
    exit 0
fi

echo "No pass line found in ${log_file}"
exit 1
